// ==== src/fp_format_pkg.sv ====
// single precision widths, word and field types, unpacked operand struct
`default_nettype none

package fp_format_pkg;

    // ieee 754 single precision fields
    localparam int sig_bits  = 23;
    localparam int exp_bits  = 8;
    localparam int exp_bias  = 127;
    // all ones exponent marks infinity
    localparam int exp_max   = 2 * exp_bias + 1;
    localparam int word_bits = 1 + exp_bits + sig_bits;

    // guard, round and sticky below the fraction
    localparam int grs_bits  = 3;
    // hidden bit + fraction + grs
    localparam int work_bits = sig_bits + 1 + grs_bits;
    // extra msb catches the add carry
    localparam int sum_bits  = work_bits + 1;

    typedef logic [word_bits-1:0] fp_word_t;
    typedef logic [exp_bits-1:0]  fp_exp_t;
    typedef logic [work_bits-1:0] fp_work_t;
    typedef logic [sum_bits-1:0]  fp_sum_t;

    // operand after unpack, significand already in working layout
    typedef struct packed {
        logic     sign;
        fp_exp_t  exp;
        fp_work_t sig;
    } fp_unpacked;

endpackage

`default_nettype wire

// ==== src/fp_add_ctrl_pkg.sv ====
// control path state encoding and normalization shift limits
`default_nettype none

package fp_add_ctrl_pkg;

    // worst cancellation leaves the leading one at bit 0
    localparam int norm_max_steps = fp_format_pkg::work_bits - 1;
    // counter has to reach norm_max_steps itself
    localparam int cnt_bits = $clog2(norm_max_steps + 1);

    // operation sequence
    typedef enum logic [2:0] {
        st_idle,
        st_align,
        st_add,
        st_norm,
        st_round,
        st_finish
    } add_state;

endpackage

`default_nettype wire

// ==== src/sig_path_if.sv ====
// significand path interface between swap, align and add stages
`timescale 1ns/1ps
`default_nettype none

interface sig_path_if;
    import fp_format_pkg::*;

    // larger operand passes straight through
    fp_work_t big_sig;
    // smaller operand before and after the right shift
    fp_work_t small_sig;
    fp_work_t small_aligned;
    // exponent difference, already saturated
    fp_exp_t  shift;
    fp_exp_t  exp_big;
    logic     sign_big;
    logic     sign_small;
    // signs differ so magnitudes subtract
    logic     eff_sub;

    modport producer (output big_sig, small_sig, shift, exp_big, sign_big, sign_small, eff_sub);
    modport aligner  (input small_sig, shift, output small_aligned);
    modport consumer (input big_sig, small_sig, small_aligned, shift, exp_big, sign_big,
                      sign_small, eff_sub);

endinterface

`default_nettype wire

// ==== src/exp_compare.sv ====
// exp_compare: operand unpack, magnitude swap, exponent difference register
`timescale 1ns/1ps
`default_nettype none

module exp_compare (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    load,
    input  fp_format_pkg::fp_word_t a,
    input  fp_format_pkg::fp_word_t b,
    input  logic                    sub,
    sig_path_if.producer            sp
);
    import fp_format_pkg::*;

    fp_unpacked op_a;
    fp_unpacked op_b;
    fp_unpacked op_big;
    fp_unpacked op_small;
    logic       a_big;
    fp_exp_t    exp_diff;

    // exponent field 0 flushes to zero
    // zero keeps exponent 0 so it always aligns away
    function automatic fp_unpacked unpack(input fp_word_t w, input logic flip);
        fp_unpacked u;
        u.sign = w[word_bits-1] ^ flip;
        u.exp  = w[word_bits-2 -: exp_bits];
        u.sig  = (u.exp == '0) ? '0 : {1'b1, w[sig_bits-1:0], {grs_bits{1'b0}}};
        return u;
    endfunction

    always_comb begin
        op_a = unpack(a, 1'b0);
        // subtract is add with b negated
        op_b = unpack(b, sub);
        // exponent first, then significand
        a_big    = {op_a.exp, op_a.sig} >= {op_b.exp, op_b.sig};
        op_big   = a_big ? op_a : op_b;
        op_small = a_big ? op_b : op_a;
        exp_diff = op_big.exp - op_small.exp;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sp.big_sig    <= '0;
            sp.small_sig  <= '0;
            sp.exp_big    <= '0;
            sp.sign_big   <= 1'b0;
            sp.sign_small <= 1'b0;
            sp.shift      <= '0;
        end else if (load) begin
            sp.big_sig    <= op_big.sig;
            sp.small_sig  <= op_small.sig;
            sp.exp_big    <= op_big.exp;
            sp.sign_big   <= op_big.sign;
            sp.sign_small <= op_small.sign;
            // past work_bits everything is sticky anyway
            sp.shift      <= (exp_diff > fp_exp_t'(work_bits)) ? fp_exp_t'(work_bits) : exp_diff;
        end
    end

    // effective operation from the registered signs
    assign sp.eff_sub = sp.sign_big ^ sp.sign_small;

endmodule

`default_nettype wire

// ==== src/align_significands.sv ====
// align_significands: right shift of the smaller significand with sticky fold
`timescale 1ns/1ps
`default_nettype none

module align_significands (
    sig_path_if.aligner sp
);
    import fp_format_pkg::*;

    fp_work_t shifted;
    logic     sticky;

    // big operand needs no shift, the swap already happened upstream
    always_comb begin
        shifted = sp.small_sig >> sp.shift;
        sticky  = 1'b0;
        if (sp.shift >= fp_exp_t'(work_bits)) begin
            // whole significand shifted out
            sticky = |sp.small_sig;
        end else if (sp.shift > fp_exp_t'(grs_bits)) begin
            // keep only the bits at or below the new sticky position
            sticky = |(sp.small_sig << (fp_exp_t'(work_bits - 1) - sp.shift));
        end
        // shifts up to 3 lose nothing, grs of the input are zero
        if (sp.shift > fp_exp_t'(grs_bits)) begin
            shifted[0] = sticky;
        end
        sp.small_aligned = shifted;
    end

endmodule

`default_nettype wire

// ==== src/sig_add.sv ====
// sig_add: significand add or subtract with result sign and exponent registers
`timescale 1ns/1ps
`default_nettype none

module sig_add (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   add_en,
    sig_path_if.consumer           sp,
    output fp_format_pkg::fp_sum_t sum,
    output logic                   res_sign,
    output fp_format_pkg::fp_exp_t res_exp
);
    import fp_format_pkg::*;

    fp_sum_t big_ext;
    fp_sum_t small_ext;

    // one bit of headroom, msb of sum is the carry
    assign big_ext   = {1'b0, sp.big_sig};
    assign small_ext = {1'b0, sp.small_aligned};

    always_ff @(posedge clk) begin
        if (reset) begin
            sum      <= '0;
            res_sign <= 1'b0;
            res_exp  <= '0;
        end else if (add_en) begin
            // big >= small after the swap, no negative result
            if (sp.eff_sub) begin
                sum <= big_ext - small_ext;
            end else begin
                sum <= big_ext + small_ext;
            end
            // result takes the larger operand's sign and exponent
            res_sign <= sp.sign_big;
            res_exp  <= sp.exp_big;
        end
    end

endmodule

`default_nettype wire

// ==== src/norm_counter.sv ====
// norm_counter: left shift counter with step and exponent limit
`timescale 1ns/1ps
`default_nettype none

module norm_counter (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   clear,
    input  logic                   step,
    input  fp_format_pkg::fp_exp_t exp,
    output logic                   limit
);
    import fp_add_ctrl_pkg::*;

    logic [cnt_bits-1:0] count;
    logic                count_full;
    logic                exp_floor;

    assign count_full = (count == cnt_bits'(norm_max_steps));
    // exponent 1 or below, one more shift would go subnormal
    assign exp_floor  = (exp[$bits(exp)-1:1] == '0);

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            count <= '0;
        end else if (step && !count_full) begin
            count <= count + 1'b1;
        end
    end

    // either reason stops normalization
    assign limit = count_full || exp_floor;

endmodule

`default_nettype wire

// ==== src/normalize_round.sv ====
// normalize_round: stepwise normalization, round to nearest even, result pack
`timescale 1ns/1ps
`default_nettype none

module normalize_round (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    add_en,
    input  logic                    norm_en,
    input  logic                    round_en,
    input  fp_format_pkg::fp_sum_t  sum,
    input  logic                    res_sign,
    input  fp_format_pkg::fp_exp_t  res_exp,
    input  logic                    limit,
    output fp_format_pkg::fp_exp_t  exp_now,
    output logic                    step,
    output logic                    norm_done,
    output fp_format_pkg::fp_word_t result
);
    import fp_format_pkg::*;

    // working copy, keeps the carry bit position
    fp_sum_t work_sig;
    fp_exp_t work_exp;
    // first norm cycle reads the fresh sum directly
    logic    fresh;

    fp_sum_t src_sig;
    fp_sum_t next_sig;
    fp_exp_t src_exp;
    fp_exp_t next_exp;
    logic    carry;
    logic    hidden;
    logic    is_zero;

    logic                round_up;
    logic [sig_bits+1:0] rounded;
    logic [exp_bits:0]   exp_round;
    logic [sig_bits-1:0] frac_out;
    fp_word_t            packed_word;

    assign src_sig = fresh ? sum : work_sig;
    assign src_exp = fresh ? res_exp : work_exp;
    assign carry   = src_sig[sum_bits-1];
    assign hidden  = src_sig[work_bits-1];
    assign is_zero = (src_sig == '0);

    // exponent as it stands once a pending carry is corrected
    assign exp_now   = src_exp + fp_exp_t'(carry);
    assign norm_done = !carry && (hidden || is_zero || limit);
    // only left shifts are counted
    assign step      = norm_en && !carry && !norm_done;

    always_comb begin
        next_sig = src_sig;
        next_exp = src_exp;
        if (carry) begin
            // right shift once, lost bit folds into sticky
            next_sig    = src_sig >> 1;
            next_sig[0] = src_sig[1] | src_sig[0];
            next_exp    = src_exp + 1'b1;
        end else if (!norm_done) begin
            next_sig = src_sig << 1;
            next_exp = src_exp - 1'b1;
        end
    end

    always_comb begin
        // guard and (round or sticky or lsb) for ties to even
        round_up = work_sig[2] && (work_sig[1] || work_sig[0] || work_sig[grs_bits]);
        rounded  = {1'b0, work_sig[work_bits-1:grs_bits]} + (sig_bits + 2)'(round_up);
        // rounding carry gives 10.000, one more exponent step
        exp_round = {1'b0, work_exp} + (exp_bits + 1)'(rounded[sig_bits+1]);
        frac_out  = rounded[sig_bits+1] ? rounded[sig_bits:1] : rounded[sig_bits-1:0];

        if (work_sig == '0) begin
            // exact cancellation and zero operands
            packed_word = '0;
        end else if (!work_sig[work_bits-1]) begin
            // stopped at limit without hidden bit, flush
            packed_word = {res_sign, {(word_bits - 1){1'b0}}};
        end else if (exp_round >= (exp_bits + 1)'(exp_max)) begin
            packed_word = {res_sign, fp_exp_t'(exp_max), {sig_bits{1'b0}}};
        end else begin
            packed_word = {res_sign, exp_round[exp_bits-1:0], frac_out};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fresh    <= 1'b0;
            work_sig <= '0;
            work_exp <= '0;
            result   <= '0;
        end else begin
            if (add_en) begin
                fresh <= 1'b1;
            end
            if (norm_en) begin
                work_sig <= next_sig;
                work_exp <= next_exp;
                fresh    <= 1'b0;
            end
            // result holds until the next round
            if (round_en) begin
                result <= packed_word;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/fp_add_fsm.sv ====
// fp_add_fsm: stage sequencing state machine with done and busy strobes
`timescale 1ns/1ps
`default_nettype none

module fp_add_fsm (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic norm_done,
    input  logic limit,
    output logic load,
    output logic add_en,
    output logic norm_en,
    output logic round_en,
    output logic clear,
    output logic done,
    output logic busy
);
    import fp_add_ctrl_pkg::*;

    add_state state;
    add_state next_state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        load       = 1'b0;
        add_en     = 1'b0;
        norm_en    = 1'b0;
        round_en   = 1'b0;
        clear      = 1'b0;
        case (state)
            // start only counts here, otherwise dropped
            st_idle: begin
                if (start) begin
                    load       = 1'b1;
                    next_state = st_align;
                end
            end
            // aligned operands go into the sum register
            st_align: begin
                add_en     = 1'b1;
                clear      = 1'b1;
                next_state = st_add;
            end
            // add cycle already takes the first normalize step
            st_add, st_norm: begin
                norm_en = 1'b1;
                if (norm_done || limit) begin
                    next_state = st_round;
                end else begin
                    next_state = st_norm;
                end
            end
            st_round: begin
                round_en   = 1'b1;
                next_state = st_finish;
            end
            st_finish: begin
                next_state = st_idle;
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    // one cycle done, busy through the done cycle
    assign done = (state == st_finish);
    assign busy = (state != st_idle);

endmodule

`default_nettype wire

// ==== src/fp_add.sv ====
// fp_add: single precision adder top level, stage instances and wiring
`timescale 1ns/1ps
`default_nettype none

module fp_add (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    input  logic                    sub,
    input  fp_format_pkg::fp_word_t a,
    input  fp_format_pkg::fp_word_t b,
    output fp_format_pkg::fp_word_t result,
    output logic                    done,
    output logic                    busy
);
    import fp_format_pkg::*;

    // fsm enables
    logic load;
    logic add_en;
    logic norm_en;
    logic round_en;
    logic clear;

    // normalization feedback
    logic    step;
    logic    limit;
    logic    norm_done;
    fp_exp_t exp_now;

    // registered add result
    fp_sum_t sum;
    logic    res_sign;
    fp_exp_t res_exp;

    sig_path_if sp ();

    exp_compare u_exp_compare (
        .clk(clk), .reset(reset), .load(load),
        .a(a), .b(b), .sub(sub),
        .sp(sp.producer)
    );

    align_significands u_align (
        .sp(sp.aligner)
    );

    sig_add u_sig_add (
        .clk(clk), .reset(reset), .add_en(add_en),
        .sp(sp.consumer),
        .sum(sum), .res_sign(res_sign), .res_exp(res_exp)
    );

    norm_counter u_norm_counter (
        .clk(clk), .reset(reset), .clear(clear), .step(step),
        .exp(exp_now), .limit(limit)
    );

    normalize_round u_normalize_round (
        .clk(clk), .reset(reset),
        .add_en(add_en), .norm_en(norm_en), .round_en(round_en),
        .sum(sum), .res_sign(res_sign), .res_exp(res_exp),
        .limit(limit), .exp_now(exp_now),
        .step(step), .norm_done(norm_done),
        .result(result)
    );

    fp_add_fsm u_fsm (
        .clk(clk), .reset(reset), .start(start),
        .norm_done(norm_done), .limit(limit),
        .load(load), .add_en(add_en), .norm_en(norm_en), .round_en(round_en),
        .clear(clear), .done(done), .busy(busy)
    );

endmodule

`default_nettype wire

// ==== sim/fp_add_tb.sv ====
// fp_add testbench with lcg stimulus, integer reference model, directed and random tests
`timescale 1ns/1ps
`default_nettype none

module fp_add_tb;
    import fp_format_pkg::*;

    // random and directed operation counts per test
    localparam int n_random    = 150;
    localparam int n_edge      = 40;
    localparam int n_directed  = 24;
    localparam int total_ops   = 3 * n_random + 2 * n_edge + n_directed;
    // worst op takes 30 cycles plus start and the idle check after done
    localparam int cycle_limit = total_ops * 32 + 100;

    logic        clk;
    logic        reset;
    logic        start;
    logic        sub;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] result;
    logic        done;
    logic        busy;

    logic [31:0] rng_state;
    int          cycle_count;
    int          check_count;
    int          error_count;

    fp_add UUT (
        .clk(clk), .reset(reset), .start(start), .sub(sub),
        .a(a), .b(b), .result(result), .done(done), .busy(busy)
    );

    // 20 ns period
    always #10 clk = ~clk;

    // run watchdog
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout: done never came, run stopped after %0d cycles", cycle_limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // upper lcg bits since the low ones repeat quickly
    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = lcg_next();
        return int'(r[31:16]) % n;
    endfunction

    function automatic logic [22:0] rand_frac();
        logic [31:0] r;
        r = lcg_next();
        return r[30:8];
    endfunction

    function automatic logic [31:0] make_fp(input logic sign, input int exp_field,
                                            input logic [22:0] frac);
        return {sign, 8'(exp_field), frac};
    endfunction

    // reference sum on wide integers with the hidden bit at 26 and grs below
    function automatic logic [31:0] model_add(input logic [31:0] x, input logic [31:0] y,
                                              input logic do_sub);
        logic        sx;
        logic        sy;
        logic        sgn;
        logic        y_big;
        int          ex;
        int          ey;
        int          e;
        int          d;
        logic [63:0] mx;
        logic [63:0] my;
        logic [63:0] m_big;
        logic [63:0] m_small;
        logic [63:0] lost;
        logic [63:0] acc;
        logic [63:0] frac;
        sx = x[31];
        sy = y[31] ^ do_sub;
        ex = int'(x[30:23]);
        ey = int'(y[30:23]);
        // exponent 0 reads as zero
        mx = (ex == 0) ? 64'd0 : {37'd0, 1'b1, x[22:0], 3'b000};
        my = (ey == 0) ? 64'd0 : {37'd0, 1'b1, y[22:0], 3'b000};
        // larger magnitude first and x wins a tie
        y_big   = (ey > ex) || (ey == ex && my > mx);
        sgn     = y_big ? sy : sx;
        e       = y_big ? ey : ex;
        m_big   = y_big ? my : mx;
        m_small = y_big ? mx : my;
        d       = y_big ? ey - ex : ex - ey;
        if (d > work_bits) begin
            d = work_bits;
        end
        // everything shifted out lands in bit 0
        lost    = m_small & ((64'd1 << d) - 64'd1);
        m_small = (m_small >> d) | {63'd0, lost != 64'd0};
        acc     = (sx ^ sy) ? m_big - m_small : m_big + m_small;
        if (acc == 64'd0) begin
            return 32'd0;
        end
        if (acc[work_bits]) begin
            // carry out needs one right shift keeping sticky
            acc = (acc >> 1) | {63'd0, acc[0]};
            e   = e + 1;
        end else begin
            while (!acc[work_bits-1] && e > 1) begin
                acc = acc << 1;
                e   = e - 1;
            end
        end
        // hidden bit never reached so below the normal range
        if (!acc[work_bits-1]) begin
            return {sgn, 31'd0};
        end
        // nearest even from guard, round, sticky and lsb
        frac = acc >> grs_bits;
        if (acc[grs_bits-1] && (acc[1] || acc[0] || frac[0])) begin
            frac = frac + 64'd1;
        end
        if (frac[sig_bits+1]) begin
            frac = frac >> 1;
            e    = e + 1;
        end
        if (e >= exp_max) begin
            return {sgn, 8'hff, 23'd0};
        end
        return {sgn, 8'(e), frac[sig_bits-1:0]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count = check_count + 1;
        if (expected !== actual) begin
            error_count = error_count + 1;
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // one cycle start strobe accepted on the second edge
    task automatic start_op(input logic [31:0] op_a, input logic [31:0] op_b,
                            input logic op_sub);
        @(posedge clk);
        start <= 1'b1;
        a     <= op_a;
        b     <= op_b;
        sub   <= op_sub;
        @(posedge clk);
        start <= 1'b0;
    endtask

    // sampled on the falling edge away from the stimulus edge
    task automatic wait_done(input string name, input logic [31:0] expected,
                             output int latency);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!done) begin
            check_value({name, " busy"}, 32'd1, {31'd0, busy});
            waited = waited + 1;
            @(negedge clk);
        end
        check_value({name, " busy at done"}, 32'd1, {31'd0, busy});
        check_value(name, expected, result);
        latency = waited + 1;
        @(negedge clk);
        // done lasts one cycle and busy ends with it
        check_value({name, " done width"}, 32'd0, {31'd0, done});
        check_value({name, " busy after done"}, 32'd0, {31'd0, busy});
    endtask

    task automatic run_op(input string test, input logic [31:0] op_a,
                          input logic [31:0] op_b, input logic op_sub,
                          input logic [31:0] expected);
        int latency;
        start_op(op_a, op_b, op_sub);
        wait_done($sformatf("%s %h %s %h", test, op_a, op_sub ? "-" : "+", op_b),
                  expected, latency);
    endtask

    // random fractions and operand order with half of them through sub
    task automatic random_op(input string test, input logic sa, input int ea,
                             input logic sb, input int eb, input logic close_frac);
        logic [22:0] fa;
        logic [22:0] fb;
        logic [31:0] first;
        logic [31:0] second;
        logic        use_sub;
        fa = rand_frac();
        fb = rand_frac();
        if (close_frac) begin
            // only low bits differ for a long cancellation
            fb = fa ^ (fb >> rand_below(sig_bits));
        end
        if (rand_below(2) == 1) begin
            first  = make_fp(sa, ea, fa);
            second = make_fp(sb, eb, fb);
        end else begin
            first  = make_fp(sb, eb, fb);
            second = make_fp(sa, ea, fa);
        end
        use_sub = rand_below(2) == 1;
        // subtracting the negated operand gives the same sum
        second[31] = second[31] ^ use_sub;
        run_op(test, first, second, use_sub, model_add(first, second, use_sub));
    endtask

    task automatic report_test(input string test, input int ops, input int errors_before);
        $display("test %s: %0d operations, %0d errors", test, ops,
                 error_count - errors_before);
    endtask

    initial begin
        int          i;
        int          ea;
        int          d;
        logic        s;
        int          errors_before;
        int          latency;
        logic [31:0] hold_value;
        clk         = 1'b0;
        reset       = 1'b1;
        start       = 1'b0;
        sub         = 1'b0;
        a           = 32'd0;
        b           = 32'd0;
        rng_state   = 32'h907eff79;
        cycle_count = 0;
        check_count = 0;
        error_count = 0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        errors_before = error_count;
        @(negedge clk);
        check_value("reset result", 32'd0, result);
        check_value("reset done", 32'd0, {31'd0, done});
        check_value("reset busy", 32'd0, {31'd0, busy});
        report_test("reset_values", 0, errors_before);

        // same sign and close exponents with carry out
        errors_before = error_count;
        run_op("same_sign_add", 32'h3fc00000, 32'h3fc00000, 1'b0, 32'h40400000);
        for (i = 0; i < n_random; i++) begin
            s  = rand_below(2) == 1;
            ea = 64 + rand_below(128);
            random_op("same_sign_add", s, ea, s, ea - rand_below(4), 1'b0);
        end
        report_test("same_sign_add", n_random + 1, errors_before);

        // opposite signs with equal or adjacent exponents
        errors_before = error_count;
        run_op("cancellation", 32'h3f800000, 32'h3f7fffff, 1'b1, 32'h33800000);
        run_op("cancellation", 32'h3f800001, 32'h3f800000, 1'b1, 32'h34000000);
        for (i = 0; i < n_random; i++) begin
            s  = rand_below(2) == 1;
            ea = 64 + rand_below(128);
            random_op("cancellation", s, ea, !s, ea - rand_below(2), 1'b1);
        end
        report_test("cancellation", n_random + 2, errors_before);

        // sticky, ties to even and rounding carry
        errors_before = error_count;
        run_op("far_align", 32'h3f800000, 32'h33800000, 1'b0, 32'h3f800000);
        run_op("far_align", 32'h3f800001, 32'h33800000, 1'b0, 32'h3f800002);
        run_op("far_align", 32'h3fffffff, 32'h33800000, 1'b0, 32'h40000000);
        run_op("far_align", 32'h3f800000, 32'h33800001, 1'b0, 32'h3f800001);
        run_op("far_align", 32'h3f800000, 32'h33800000, 1'b1, 32'h3f7fffff);
        run_op("far_align", 32'h3f800000, 32'h2f800000, 1'b0, 32'h3f800000);
        run_op("far_align", 32'h3f800000, 32'h2f800000, 1'b1, 32'h3f800000);
        for (i = 0; i < n_random; i++) begin
            d  = (i % 2 == 0) ? 4 + rand_below(23) : 27 + rand_below(40);
            ea = 80 + rand_below(120);
            random_op("far_align", rand_below(2) == 1, ea, rand_below(2) == 1, ea - d, 1'b0);
        end
        report_test("far_align", n_random + 7, errors_before);

        // zero operands, flush below normal and saturation to infinity
        errors_before = error_count;
        run_op("zero_flush_overflow", 32'h00000000, 32'h40490fdb, 1'b0, 32'h40490fdb);
        run_op("zero_flush_overflow", 32'hc0490fdb, 32'h00000000, 1'b0, 32'hc0490fdb);
        run_op("zero_flush_overflow", 32'h00000000, 32'h00000000, 1'b0, 32'h00000000);
        run_op("zero_flush_overflow", 32'h80000000, 32'h80000000, 1'b0, 32'h00000000);
        run_op("zero_flush_overflow", 32'h40490fdb, 32'h40490fdb, 1'b1, 32'h00000000);
        run_op("zero_flush_overflow", 32'hc0490fdb, 32'h40490fdb, 1'b0, 32'h00000000);
        run_op("zero_flush_overflow", 32'h00800000, 32'h00c00000, 1'b1, 32'h80000000);
        // difference lands exactly on the smallest normal
        run_op("zero_flush_overflow", 32'h01400000, 32'h01000000, 1'b1, 32'h00800000);
        run_op("zero_flush_overflow", 32'h00800000, 32'h00800000, 1'b0, 32'h01000000);
        run_op("zero_flush_overflow", 32'h7f7fffff, 32'h7f7fffff, 1'b0, 32'h7f800000);
        run_op("zero_flush_overflow", 32'hff7fffff, 32'h7f7fffff, 1'b1, 32'hff800000);
        run_op("zero_flush_overflow", 32'h7f7fffff, 32'h73000000, 1'b0, 32'h7f800000);
        for (i = 0; i < n_edge; i++) begin
            s = rand_below(2) == 1;
            random_op("zero_flush_overflow", s, 1 + rand_below(4), !s, 1 + rand_below(4), 1'b1);
        end
        for (i = 0; i < n_edge; i++) begin
            s = rand_below(2) == 1;
            random_op("zero_flush_overflow", s, 250 + rand_below(5), s, 250 + rand_below(5),
                      1'b0);
        end
        report_test("zero_flush_overflow", 2 * n_edge + 12, errors_before);

        // done width, busy span and a start dropped while busy
        errors_before = error_count;
        start_op(32'h3fc00000, 32'h3fc00000, 1'b0);
        wait_done("handshake", 32'h40400000, latency);
        // minimum of 4 plus one carry correction cycle
        check_value("handshake latency", 32'd5, 32'(latency));
        hold_value = model_add(32'h40490fdb, 32'h3f800000, 1'b0);
        start_op(32'h40490fdb, 32'h3f800000, 1'b0);
        @(posedge clk);
        start <= 1'b1;
        a     <= 32'h3f800000;
        b     <= 32'h3f800000;
        sub   <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        wait_done("handshake dropped start", hold_value, latency);
        repeat (10) begin
            @(negedge clk);
            check_value("handshake extra done", 32'd0, {31'd0, done});
            check_value("handshake idle busy", 32'd0, {31'd0, busy});
            check_value("handshake result hold", hold_value, result);
        end
        report_test("handshake", 2, errors_before);

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== fp_add.f ====
src/fp_format_pkg.sv
src/fp_add_ctrl_pkg.sv
src/sig_path_if.sv
src/exp_compare.sv
src/align_significands.sv
src/sig_add.sv
src/norm_counter.sv
src/normalize_round.sv
src/fp_add_fsm.sv
src/fp_add.sv
sim/fp_add_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the fp_add testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module fp_add_tb -f fp_add.f -o fp_add_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/fp_add_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "TESTS PASSED" "$LOG"; then
    echo "simulation log holds no final result"
    exit 1
fi
exit 0
